// ==== src/bicubic_settings.svh ====
`ifndef BICUBIC_SETTINGS_SVH
`define BICUBIC_SETTINGS_SVH

// source image is square
`define IMG_W 100

`define PIX_W 8
`define FRAC_W 8    // Q0.8

// row, column, quotient and remainder
`define COORD_W 7

// {row, col} for the SRAM, row*100+col for the ROM
`define ADDR_W 14

`endif

// ==== src/scaler_pkg.sv ====
`include "bicubic_settings.svh"

package scaler_pkg;

    typedef logic [`COORD_W-1:0] coord_t;

    // source window and target size
    typedef struct packed {
        logic [`COORD_W-1:0] v0;
        logic [`COORD_W-1:0] h0;
        logic [4:0]          sw;
        logic [4:0]          sh;
        logic [5:0]          tw;
        logic [5:0]          th;
    } scale_cfg_t;

    // one target pixel with its source position
    typedef struct packed {
        coord_t tgt_row;
        coord_t tgt_col;
        coord_t quot_v;
        coord_t quot_h;
        coord_t rem_v;
        coord_t rem_h;
    } pixel_job_t;

    typedef enum logic [2:0] {
        IDLE,
        DIVIDE,
        FETCH,
        HPASS,   // last row draining, vertical frac loading
        VPASS,
        WRITE
    } seq_state_e;

endpackage

// ==== src/mem_pkg.sv ====
`include "bicubic_settings.svh"

package mem_pkg;

    typedef logic [`PIX_W-1:0] pixel_t;

    typedef struct packed {
        logic              cen_n;   // active low
        logic [`ADDR_W-1:0] addr;
    } rom_req_t;

    typedef struct packed {
        logic              cen_n;
        logic              wen_n;   // low = write
        logic [`ADDR_W-1:0] addr;
        pixel_t            data;
    } sram_req_t;

    typedef enum logic {
        OP_HOLD,
        OP_WRITE
    } sram_op_e;

endpackage

// ==== src/frac_divider.sv ====
`timescale 1ns/10ps
`include "bicubic_settings.svh"

module frac_divider (
    input  logic               CLK,
    input  logic               RST,
    input  logic               start_i,
    input  scaler_pkg::coord_t rem_i,
    input  scaler_pkg::coord_t span_i,
    output mem_pkg::pixel_t    frac_o,
    output logic               done_o
);
    import scaler_pkg::*;

    coord_t           part_q;     // partial remainder, always below span
    coord_t           span_q;
    logic [3:0]       iter_q;
    logic [`COORD_W:0] shifted;
    logic             fits;

    assign shifted = {part_q, 1'b0};
    assign fits    = (shifted >= {1'b0, span_q});

    always_ff @(posedge CLK) begin
        if (RST) begin
            iter_q <= '0;
            done_o <= 1'b0;
        end else begin
            done_o <= 1'b0;
            if (start_i) begin
                iter_q <= 4'(`FRAC_W);
            end else if (iter_q != '0) begin
                iter_q <= iter_q - 4'd1;
                if (iter_q == 4'd1) begin
                    done_o <= 1'b1;
                end
            end
        end
    end

    // one quotient bit per cycle, msb first
    always_ff @(posedge CLK) begin
        if (start_i) begin
            part_q <= rem_i;
            span_q <= span_i;
        end else if (iter_q != '0) begin
            part_q <= fits ? coord_t'(shifted - {1'b0, span_q}) : coord_t'(shifted);
            frac_o <= {frac_o[`FRAC_W-2:0], fits};
        end
    end

endmodule

// ==== src/cubic_engine.sv ====
`timescale 1ns/10ps

module cubic_engine (
    input  logic            CLK,
    input  logic            RST,
    input  logic            load_i,
    input  mem_pkg::pixel_t frac_i,
    input  mem_pkg::pixel_t p_i,
    input  logic            p_valid_i,
    output mem_pkg::pixel_t res_o,
    output logic            res_valid_o
);
    import mem_pkg::*;

    localparam int ACC_W = 22;
    localparam logic signed [ACC_W-1:0] HALF = ACC_W'(256);

    pixel_t f1_q, x2_1_q;           // stage 1
    logic   st1_vld_q;
    pixel_t frac_q, x2_q, x3_q;     // set used by the MAC
    logic [15:0] sq, cu;

    logic signed [11:0]      f_s, x2_s, x3_s, coef;
    logic signed [ACC_W-1:0] term, sum, acc_q, rnd;
    logic [1:0]              idx_q;

    assign sq = frac_i * frac_i + 16'd128;
    assign cu = x2_1_q * f1_q + 16'd128;

    always_ff @(posedge CLK) begin
        if (load_i) begin
            f1_q   <= frac_i;
            x2_1_q <= sq[15:8];
        end
        if (st1_vld_q) begin
            frac_q <= f1_q;
            x2_q   <= x2_1_q;
            x3_q   <= cu[15:8];
        end
    end

    assign f_s  = $signed({4'b0, frac_q});
    assign x2_s = $signed({4'b0, x2_q});
    assign x3_s = $signed({4'b0, x3_q});

    // Catmull-Rom weight of tap idx, scaled by 512
    always_comb begin
        case (idx_q)
            2'd0:    coef = (x2_s <<< 1) - f_s - x3_s;
            2'd1:    coef = 12'sd512 - 12'sd5 * x2_s + 12'sd3 * x3_s;
            2'd2:    coef = f_s + (x2_s <<< 2) - 12'sd3 * x3_s;
            default: coef = x3_s - x2_s;
        endcase
    end

    assign term = ACC_W'(coef) * ACC_W'($signed({1'b0, p_i}));
    assign sum  = (idx_q == 2'd0) ? term : acc_q + term;
    assign rnd  = (sum + HALF) >>> 9;

    always_ff @(posedge CLK) begin
        if (RST) begin
            st1_vld_q   <= 1'b0;
            idx_q       <= '0;
            res_valid_o <= 1'b0;
        end else begin
            st1_vld_q   <= load_i;
            res_valid_o <= p_valid_i && (idx_q == 2'd3);
            if (p_valid_i) begin
                idx_q <= idx_q + 2'd1;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (p_valid_i) begin
            acc_q <= sum;
            if (idx_q == 2'd3) begin
                if (rnd[ACC_W-1]) begin
                    res_o <= '0;          // undershoot
                end else if (|rnd[ACC_W-2:8]) begin
                    res_o <= '1;
                end else begin
                    res_o <= rnd[7:0];
                end
            end
        end
    end

endmodule

// ==== src/scale_stepper.sv ====
`timescale 1ns/10ps

module scale_stepper (
    input  logic                   CLK,
    input  logic                   RST,
    input  scaler_pkg::scale_cfg_t cfg_i,
    input  logic                   pixel_done_i,
    output scaler_pkg::pixel_job_t job_o,
    output logic                   job_valid_o,
    output logic                   done_o
);
    import scaler_pkg::*;

    coord_t row_q, col_q;
    coord_t quot_v_q, quot_h_q;
    coord_t rem_v_q, rem_h_q;
    logic   started_q;

    coord_t span_v, span_h;   // T-1
    coord_t inc_v, inc_h;     // S-1
    coord_t sum_v, sum_h;
    logic   carry_v, carry_h;
    logic   last_row, last_col;

    assign span_v = coord_t'(cfg_i.th) - coord_t'(1);
    assign span_h = coord_t'(cfg_i.tw) - coord_t'(1);
    assign inc_v  = coord_t'(cfg_i.sh) - coord_t'(1);
    assign inc_h  = coord_t'(cfg_i.sw) - coord_t'(1);

    assign sum_v   = rem_v_q + inc_v;
    assign sum_h   = rem_h_q + inc_h;
    assign carry_v = (sum_v >= span_v);
    assign carry_h = (sum_h >= span_h);

    assign last_row = (row_q == span_v);
    assign last_col = (col_q == span_h);

    always_ff @(posedge CLK) begin
        if (RST) begin
            row_q       <= '0;
            col_q       <= '0;
            quot_v_q    <= '0;
            quot_h_q    <= '0;
            rem_v_q     <= '0;
            rem_h_q     <= '0;
            started_q   <= 1'b0;
            job_valid_o <= 1'b0;
            done_o      <= 1'b0;
        end else begin
            started_q   <= 1'b1;
            job_valid_o <= !started_q;   // first job right out of reset
            if (pixel_done_i && !done_o) begin
                if (last_row) begin
                    // column finished, rewind rows
                    row_q    <= '0;
                    quot_v_q <= '0;
                    rem_v_q  <= '0;
                    if (last_col) begin
                        done_o <= 1'b1;
                    end else begin
                        col_q       <= col_q + coord_t'(1);
                        rem_h_q     <= carry_h ? sum_h - span_h : sum_h;
                        quot_h_q    <= quot_h_q + coord_t'(carry_h);
                        job_valid_o <= 1'b1;
                    end
                end else begin
                    row_q       <= row_q + coord_t'(1);
                    rem_v_q     <= carry_v ? sum_v - span_v : sum_v;
                    quot_v_q    <= quot_v_q + coord_t'(carry_v);
                    job_valid_o <= 1'b1;
                end
            end
        end
    end

    assign job_o = '{
        tgt_row: row_q,
        tgt_col: col_q,
        quot_v:  quot_v_q,
        quot_h:  quot_h_q,
        rem_v:   rem_v_q,
        rem_h:   rem_h_q
    };

endmodule

// ==== src/pixel_sequencer.sv ====
`timescale 1ns/10ps
`include "bicubic_settings.svh"

module pixel_sequencer (
    input  logic                   CLK,
    input  logic                   RST,
    input  scaler_pkg::scale_cfg_t cfg_i,
    input  scaler_pkg::pixel_job_t job_i,
    input  logic                   job_valid_i,
    input  mem_pkg::pixel_t        rom_data_i,
    output mem_pkg::rom_req_t      rom_o,
    output mem_pkg::sram_req_t     sram_o,
    output logic                   pixel_done_o,
    output logic                   div_start_o,
    input  mem_pkg::pixel_t        frac_h_i,
    input  mem_pkg::pixel_t        frac_v_i,
    input  logic                   div_done_i,
    output logic                   eng_load_o,
    output mem_pkg::pixel_t        eng_frac_o,
    output mem_pkg::pixel_t        eng_p_o,
    output logic                   eng_p_valid_o,
    input  mem_pkg::pixel_t        eng_res_i,
    input  logic                   eng_res_valid_i
);
    import scaler_pkg::*;
    import mem_pkg::*;

    seq_state_e state_q;
    logic [3:0] cnt_q;       // window read index, then vertical tap
    logic [1:0] res_cnt_q;   // horizontal results collected
    logic       p_vld_q;     // rom byte on rom_data_i this cycle
    pixel_t     colbuf [4];

    logic [`ADDR_W-1:0] src_row;
    logic [`ADDR_W-1:0] src_col;
    sram_op_e           sram_op;

    always_ff @(posedge CLK) begin
        if (RST) begin
            state_q     <= IDLE;
            cnt_q       <= '0;
            res_cnt_q   <= '0;
            p_vld_q     <= 1'b0;
            div_start_o <= 1'b0;
        end else begin
            div_start_o <= 1'b0;
            p_vld_q     <= (state_q == FETCH);
            if (eng_res_valid_i && (state_q == FETCH || state_q == HPASS)) begin
                res_cnt_q <= res_cnt_q + 2'd1;
            end
            case (state_q)
                IDLE: begin
                    if (job_valid_i) begin
                        state_q     <= DIVIDE;
                        div_start_o <= 1'b1;
                    end
                end
                DIVIDE: begin
                    if (div_done_i) begin
                        state_q <= FETCH;
                        cnt_q   <= '0;
                    end
                end
                FETCH: begin
                    cnt_q <= cnt_q + 4'd1;
                    if (cnt_q == 4'd15) begin
                        state_q <= HPASS;
                    end
                end
                HPASS: begin
                    // wait for the fourth row result
                    if (eng_res_valid_i && res_cnt_q == 2'd3) begin
                        state_q <= VPASS;
                        cnt_q   <= '0;
                    end
                end
                VPASS: begin
                    cnt_q <= cnt_q + 4'd1;
                    if (cnt_q == 4'd3) begin
                        state_q <= WRITE;
                    end
                end
                WRITE: begin
                    if (eng_res_valid_i) begin
                        state_q <= IDLE;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (eng_res_valid_i && state_q != WRITE) begin
            colbuf[res_cnt_q] <= eng_res_i;
        end
    end

    // window is rows quot_v-1..quot_v+2, cols quot_h-1..quot_h+2
    assign src_row = `ADDR_W'(cfg_i.v0) + `ADDR_W'(job_i.quot_v)
                   + `ADDR_W'(cnt_q[3:2]) - `ADDR_W'(1);
    assign src_col = `ADDR_W'(cfg_i.h0) + `ADDR_W'(job_i.quot_h)
                   + `ADDR_W'(cnt_q[1:0]) - `ADDR_W'(1);

    always_comb begin
        rom_o.cen_n = (state_q != FETCH);
        rom_o.addr  = src_row * `ADDR_W'(`IMG_W) + src_col;
    end

    // horizontal frac when the dividers finish, vertical one with the last rom byte
    assign eng_load_o    = (state_q == DIVIDE && div_done_i) || (state_q == HPASS && p_vld_q);
    assign eng_frac_o    = (state_q == DIVIDE) ? frac_h_i : frac_v_i;
    assign eng_p_valid_o = p_vld_q || (state_q == VPASS);
    assign eng_p_o       = (state_q == VPASS) ? colbuf[cnt_q[1:0]] : rom_data_i;

    assign sram_op      = (state_q == WRITE && eng_res_valid_i) ? OP_WRITE : OP_HOLD;
    assign pixel_done_o = (sram_op == OP_WRITE);

    always_comb begin
        sram_o.cen_n = (sram_op == OP_HOLD);
        sram_o.wen_n = (sram_op == OP_HOLD);
        sram_o.addr  = {job_i.tgt_row, job_i.tgt_col};
        sram_o.data  = eng_res_i;
    end

endmodule

// ==== src/bicubic_top.sv ====
`timescale 1ns/10ps

module bicubic_top (
    input  logic                   CLK,
    input  logic                   RST,
    input  scaler_pkg::scale_cfg_t cfg_i,
    input  mem_pkg::pixel_t        rom_data_i,
    output mem_pkg::rom_req_t      rom_o,
    output mem_pkg::sram_req_t     sram_o,
    output logic                   done_o
);
    import scaler_pkg::*;
    import mem_pkg::*;

    pixel_job_t job;
    logic       job_valid;
    logic       pixel_done;

    logic       div_start;
    logic       div_done;
    pixel_t     frac_h;
    pixel_t     frac_v;

    logic       eng_load;
    pixel_t     eng_frac;
    pixel_t     eng_p;
    logic       eng_p_valid;
    pixel_t     eng_res;
    logic       eng_res_valid;

    scale_stepper stepper_i (
        .CLK          (CLK),
        .RST          (RST),
        .cfg_i        (cfg_i),
        .pixel_done_i (pixel_done),
        .job_o        (job),
        .job_valid_o  (job_valid),
        .done_o       (done_o)
    );

    // job stays put until pixel_done, so the remainders feed the dividers directly
    frac_divider div_h_i (
        .CLK     (CLK),
        .RST     (RST),
        .start_i (div_start),
        .rem_i   (job.rem_h),
        .span_i  (coord_t'(cfg_i.tw) - coord_t'(1)),
        .frac_o  (frac_h),
        .done_o  (div_done)
    );

    frac_divider div_v_i (
        .CLK     (CLK),
        .RST     (RST),
        .start_i (div_start),
        .rem_i   (job.rem_v),
        .span_i  (coord_t'(cfg_i.th) - coord_t'(1)),
        .frac_o  (frac_v),
        .done_o  ()         // same latency as div_h_i
    );

    pixel_sequencer seq_i (
        .CLK             (CLK),
        .RST             (RST),
        .cfg_i           (cfg_i),
        .job_i           (job),
        .job_valid_i     (job_valid),
        .rom_data_i      (rom_data_i),
        .rom_o           (rom_o),
        .sram_o          (sram_o),
        .pixel_done_o    (pixel_done),
        .div_start_o     (div_start),
        .frac_h_i        (frac_h),
        .frac_v_i        (frac_v),
        .div_done_i      (div_done),
        .eng_load_o      (eng_load),
        .eng_frac_o      (eng_frac),
        .eng_p_o         (eng_p),
        .eng_p_valid_o   (eng_p_valid),
        .eng_res_i       (eng_res),
        .eng_res_valid_i (eng_res_valid)
    );

    cubic_engine engine_i (
        .CLK         (CLK),
        .RST         (RST),
        .load_i      (eng_load),
        .frac_i      (eng_frac),
        .p_i         (eng_p),
        .p_valid_i   (eng_p_valid),
        .res_o       (eng_res),
        .res_valid_o (eng_res_valid)
    );

endmodule

// ==== sim/bicubic_chk.sv ====
`timescale 1ns/10ps
`include "bicubic_settings.svh"

module bicubic_chk (
    input logic                   CLK,
    input logic                   RST,
    input scaler_pkg::scale_cfg_t cfg_i,
    input mem_pkg::rom_req_t      rom_o,
    input mem_pkg::sram_req_t     sram_o,
    input logic                   done_o
);
    logic                sram_wr;
    logic [`COORD_W-1:0] wr_row;
    logic [`COORD_W-1:0] wr_col;
    int                  fail_cnt = 0;

    assign sram_wr = !sram_o.cen_n && !sram_o.wen_n;
    assign wr_row  = sram_o.addr[`ADDR_W-1:`COORD_W];
    assign wr_col  = sram_o.addr[`COORD_W-1:0];

    done_sticky: assert property (@(posedge CLK) $fell(done_o) |-> $past(RST))
        else begin
            $error("DONE dropped while reset was low");
            fail_cnt++;
        end

    no_write_after_done: assert property (@(posedge CLK) disable iff (RST)
        done_o |-> !sram_wr)
        else begin
            $error("SRAM written after DONE");
            fail_cnt++;
        end

    // target frame only
    write_in_frame: assert property (@(posedge CLK) disable iff (RST)
        sram_wr |-> (wr_row < {1'b0, cfg_i.th} && wr_col < {1'b0, cfg_i.tw}))
        else begin
            $error("SRAM write outside the target frame");
            fail_cnt++;
        end

    rom_in_range: assert property (@(posedge CLK) disable iff (RST)
        !rom_o.cen_n |-> (rom_o.addr < `ADDR_W'(`IMG_W * `IMG_W)))
        else begin
            $error("ROM address beyond the image");
            fail_cnt++;
        end

endmodule

bind bicubic_top bicubic_chk chk_i (
    .CLK    (CLK),
    .RST    (RST),
    .cfg_i  (cfg_i),
    .rom_o  (rom_o),
    .sram_o (sram_o),
    .done_o (done_o)
);

// ==== sim/tb_bicubic.sv ====
`timescale 1ns/10ps
`include "bicubic_settings.svh"

module tb_bicubic;
    import scaler_pkg::*;
    import mem_pkg::*;

    localparam int TIMEOUT_CYCLES = 200000;
    localparam int SRAM_W         = 128;

    logic       CLK      = 1'b0;
    logic       RST      = 1'b1;
    scale_cfg_t cfg      = '0;
    pixel_t     rom_data = '0;
    rom_req_t   rom_req;
    sram_req_t  sram_req;
    logic       done;

    pixel_t      rom_mem  [`IMG_W*`IMG_W];
    pixel_t      sram_mem [SRAM_W*SRAM_W];
    logic        written  [SRAM_W*SRAM_W];
    pixel_t      rom_pend = '0;
    int          model_px [64*64];   // row*64 + col
    logic [31:0] rng;
    int          n_pass;
    int          n_fail;
    int          test_errs;
    logic        aborted;

    always #2 CLK = ~CLK;

    bicubic_top dut_i (
        .CLK        (CLK),
        .RST        (RST),
        .cfg_i      (cfg),
        .rom_data_i (rom_data),
        .rom_o      (rom_req),
        .sram_o     (sram_req),
        .done_o     (done)
    );

    // rom data lands one cycle after the request, sram writes take effect at once
    always @(negedge CLK) begin
        rom_data <= rom_pend;
        if (!rom_req.cen_n) begin
            rom_pend <= rom_mem[rom_req.addr];
        end
        if (!sram_req.cen_n && !sram_req.wen_n) begin
            sram_mem[sram_req.addr] = sram_req.data;
            written[sram_req.addr]  = 1'b1;
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic int pick(input int lo, input int hi);
        rng = xorshift(rng);
        return lo + int'(rng % 32'(hi - lo + 1));
    endfunction

    function automatic int src_px(input int r, input int c);
        return int'(rom_mem[r*`IMG_W + c]);
    endfunction

    function automatic int frac_of(input int rem, input int span);
        int f;
        f = (rem * 256) / span;
        return (f > 255) ? 255 : f;   // Q0.8 stops just short of one
    endfunction

    function automatic int cubic(input int p0, input int p1, input int p2, input int p3,
                                 input int f);
        int x2, x3, s, r;
        x2 = (f * f + 128) >> 8;
        x3 = (x2 * f + 128) >> 8;
        s  = 512*p1 + f*(p2 - p0) + x2*(2*p0 - 5*p1 + 4*p2 - p3)
           + x3*(3*p1 - 3*p2 + p3 - p0);
        r  = (s + 256) >>> 9;   // floor
        if (r < 0) begin
            r = 0;
        end else if (r > 255) begin
            r = 255;
        end
        return r;
    endfunction

    function automatic scale_cfg_t make_cfg(input int sw, input int sh,
                                            input int tw, input int th);
        scale_cfg_t c;
        c.sw = 5'(sw);
        c.sh = 5'(sh);
        c.tw = 6'(tw);
        c.th = 6'(th);
        c.v0 = 7'(pick(1, 98 - sh));
        c.h0 = 7'(pick(1, 98 - sw));
        return c;
    endfunction

    task automatic check_value(input string name, input int expected, input int actual);
        if (expected !== actual) begin
            $display("[FAIL] %s: expected %0d, actual %0d", name, expected, actual);
            test_errs++;
        end
    endtask

    // 0 random, 1 constant, 2 checkerboard of 2x2 squares
    task automatic fill_rom(input int mode, input int value);
        int r, c;
        for (r = 0; r < `IMG_W; r++) begin
            for (c = 0; c < `IMG_W; c++) begin
                case (mode)
                    0:       rom_mem[r*`IMG_W + c] = pixel_t'(pick(0, 255));
                    1:       rom_mem[r*`IMG_W + c] = pixel_t'(value);
                    default: rom_mem[r*`IMG_W + c] = (((r >> 1) ^ (c >> 1)) & 1) ? 8'hff : 8'h00;
                endcase
            end
        end
    endtask

    // column-major walk, four row passes then one column pass
    task automatic build_model(input scale_cfg_t c);
        int i, j, k, qh, rh, qv, rv, fh, fv, r, col;
        int span_h, span_v;
        int hres [4];
        span_h = int'(c.tw) - 1;
        span_v = int'(c.th) - 1;
        qh = 0;
        rh = 0;
        for (j = 0; j < int'(c.tw); j++) begin
            fh  = frac_of(rh, span_h);
            col = int'(c.h0) + qh - 1;
            qv  = 0;
            rv  = 0;
            for (i = 0; i < int'(c.th); i++) begin
                fv = frac_of(rv, span_v);
                for (k = 0; k < 4; k++) begin
                    r = int'(c.v0) + qv - 1 + k;
                    hres[k] = cubic(src_px(r, col), src_px(r, col + 1),
                                    src_px(r, col + 2), src_px(r, col + 3), fh);
                end
                model_px[i*64 + j] = cubic(hres[0], hres[1], hres[2], hres[3], fv);
                rv = rv + int'(c.sh) - 1;
                if (rv >= span_v) begin
                    rv = rv - span_v;
                    qv++;
                end
            end
            rh = rh + int'(c.sw) - 1;
            if (rh >= span_h) begin
                rh = rh - span_h;
                qh++;
            end
        end
    endtask

    task automatic run_scaler(input scale_cfg_t c, output logic ok);
        int cycles;
        int a;
        @(negedge CLK);
        RST = 1'b1;
        cfg = c;
        for (a = 0; a < SRAM_W*SRAM_W; a++) begin
            written[a] = 1'b0;
        end
        repeat (2) @(negedge CLK);
        RST    = 1'b0;
        ok     = 1'b0;
        cycles = 0;
        while (!ok && cycles < TIMEOUT_CYCLES) begin
            @(negedge CLK);
            ok = done;
            cycles++;
        end
    endtask

    task automatic compare_output(input string name, input scale_cfg_t c);
        int i, j, a;
        for (j = 0; j < int'(c.tw); j++) begin
            for (i = 0; i < int'(c.th); i++) begin
                a = i * SRAM_W + j;
                if (!written[a]) begin
                    check_value($sformatf("%s write at (%0d,%0d)", name, i, j), 1, 0);
                end else begin
                    check_value($sformatf("%s pixel (%0d,%0d)", name, i, j),
                                model_px[i*64 + j], int'(sram_mem[a]));
                end
            end
        end
    endtask

    task automatic run_test(input string name, input scale_cfg_t c, input logic full_checks);
        logic ok;
        int   k;
        if (aborted) begin
            return;
        end
        test_errs = 0;
        run_scaler(c, ok);
        if (!ok) begin
            $display("timeout: test %s never raised DONE within %0d cycles",
                     name, TIMEOUT_CYCLES);
            aborted = 1'b1;
            n_fail++;
            return;
        end
        compare_output(name, c);
        if (full_checks) begin
            for (k = 0; k < 20; k++) begin
                @(negedge CLK);
                check_value({name, " done held"}, 1, int'(done));
            end
            for (k = 0; k < SRAM_W*SRAM_W; k++) begin
                if (written[k] && (k / SRAM_W >= int'(c.th) || k % SRAM_W >= int'(c.tw))) begin
                    check_value($sformatf("%s stray write at %0d", name, k), 0, 1);
                end
            end
        end
        if (test_errs == 0) begin
            n_pass++;
            $display("%-12s ok", name);
        end else begin
            n_fail++;
            $display("%-12s %0d errors", name, test_errs);
        end
    endtask

    initial begin
        int         sw, sh, tw, th, i, j, value;
        scale_cfg_t c;
        rng     = 32'd27;
        n_pass  = 0;
        n_fail  = 0;
        aborted = 1'b0;

        // same size, all fractions zero
        fill_rom(0, 0);
        sw = pick(2, 20);
        sh = pick(2, 20);
        c  = make_cfg(sw, sh, sw, sh);
        for (i = 0; i < sh; i++) begin
            for (j = 0; j < sw; j++) begin
                model_px[i*64 + j] = src_px(int'(c.v0) + i, int'(c.h0) + j);
            end
        end
        run_test("identity", c, 1'b0);

        value = pick(0, 255);
        fill_rom(1, value);
        sw = pick(2, 10);
        sh = pick(2, 10);
        c  = make_cfg(sw, sh, pick(sw, 24), pick(sh, 24));
        for (i = 0; i < 64*64; i++) begin
            model_px[i] = value;
        end
        run_test("constant", c, 1'b0);

        fill_rom(0, 0);
        sw = pick(2, 12);
        sh = pick(2, 12);
        c  = make_cfg(sw, sh, pick(sw, 24), pick(sh, 24));
        build_model(c);
        run_test("upscale", c, 1'b0);

        // one more source than target, so every step carries
        fill_rom(0, 0);
        tw = pick(2, 20);
        th = pick(2, 20);
        c  = make_cfg(tw + 1, th + 1, tw, th);
        build_model(c);
        run_test("downscale", c, 1'b0);

        fill_rom(2, 0);
        sw = pick(3, 10);
        sh = pick(3, 10);
        c  = make_cfg(sw, sh, pick(sw + 4, 24), pick(sh + 4, 24));
        build_model(c);
        run_test("checker", c, 1'b1);

        $display("tests: %0d ok, %0d failing, %0d assertion failures",
                 n_pass, n_fail, dut_i.chk_i.fail_cnt);
        if (n_fail == 0 && dut_i.chk_i.fail_cnt == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
+incdir+src
src/scaler_pkg.sv
src/mem_pkg.sv
src/frac_divider.sv
src/cubic_engine.sv
src/scale_stepper.sv
src/pixel_sequencer.sv
src/bicubic_top.sv
sim/bicubic_chk.sv
sim/tb_bicubic.sv

// ==== run_sim.sh ====
#!/bin/sh
# build with Verilator, run, and look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module tb_bicubic -f sim.f &&
./obj_dir/Vtb_bicubic | tee /dev/stderr | grep -q "All tests passed" || { echo "simulation FAILED"; exit 1; }
